// File: Makefile
# Verilator build, run and lint for the command bridge

VERILATOR  ?= verilator
TOP        := hps_cmd_bridge_tb
FILELIST   := hps_cmd_bridge.f
OBJ_DIR    := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "All tests passed" $(LOG) || { echo "Simulation stopped early"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/hps_cmd_bridge_sva.sv
`timescale 1ns/100ps
`default_nettype none

// Strobe rules of the FIFO reader
module hps_cmd_bridge_sva (
	input logic CLOCK_50,
	input logic reset,
	input logic fifo_empty,
	input logic fifo_read,
	input logic cmd_valid
);

	// cmd_valid over the last three cycles
	logic [2:0] valid_hist;

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			valid_hist <= '0;
		end else begin
			valid_hist <= {valid_hist[1:0], cmd_valid};
		end
	end

	// ========================================
	// Read strobe
	// ========================================
	assert property (@(posedge CLOCK_50) disable iff (reset)
		fifo_read |=> !fifo_read)
		else $error("fifo_read high for two consecutive cycles");

	// Request only on a non-empty FIFO
	assert property (@(posedge CLOCK_50) disable iff (reset)
		$rose(fifo_read) |-> !$past(fifo_empty))
		else $error("fifo_read rose while the FIFO was empty");

	// ========================================
	// Valid pulse
	// ========================================
	assert property (@(posedge CLOCK_50) disable iff (reset)
		cmd_valid |=> !cmd_valid)
		else $error("cmd_valid longer than one cycle");

	// Next capture needs a full pass through the FSM
	assert property (@(posedge CLOCK_50) disable iff (reset)
		cmd_valid |-> (valid_hist == '0))
		else $error("cmd_valid repeated within four cycles");

endmodule

bind cmd_fifo_reader hps_cmd_bridge_sva hps_cmd_bridge_sva_i (
	.CLOCK_50   (CLOCK_50),
	.reset      (reset),
	.fifo_empty (fifo_empty),
	.fifo_read  (fifo_read),
	.cmd_valid  (cmd_valid)
);

`default_nettype wire

// File: dv/hps_cmd_bridge_tb.sv
`timescale 1ns/100ps
`default_nettype none

// Testbench for the command bridge, processor FIFO modeled by a queue
module hps_cmd_bridge_tb
	import bridge_pkg::*;
	import display_pkg::*;
();

	// ========================================
	// Run length
	// ========================================
	localparam int NUM_RANDOM   = 40;
	localparam int NUM_HELD     = 8;
	localparam int TOTAL_WORDS  = 1 + 2 + NUM_RANDOM + NUM_HELD;
	// 200 cycles per word, margin for reset and idle stretches
	localparam int LIMIT_CYCLES = TOTAL_WORDS * 200 + 500;
	// hex5 down to hex0, then the LEDs
	localparam int OUT_W        = NUM_DIGITS * SEG_W + LED_W;

	logic              CLOCK_50 = 1'b0;
	logic              reset;
	logic              fifo_empty;
	logic [WORD_W-1:0] fifo_readdata;
	logic              fifo_read;
	logic              set_ready;
	logic [SEG_W-1:0]  hex0, hex1, hex2, hex3, hex4, hex5;
	logic [LED_W-1:0]  ledr;

	// Words in the FIFO, and words not yet seen on the display
	logic [WORD_W-1:0] fifo_q [$];
	logic [WORD_W-1:0] expect_q [$];
	logic [WORD_W-1:0] last_word    = '0;
	int                words_sent   = 0;
	int                read_count   = 0;
	int                shown_count  = 0;
	logic              checks_armed = 1'b0;
	integer            seed         = 71196;

	hps_cmd_bridge_top hps_cmd_bridge_top_i (
		.CLOCK_50      (CLOCK_50),
		.reset         (reset),
		.fifo_empty    (fifo_empty),
		.fifo_readdata (fifo_readdata),
		.fifo_read     (fifo_read),
		.set_ready     (set_ready),
		.hex0          (hex0),
		.hex1          (hex1),
		.hex2          (hex2),
		.hex3          (hex3),
		.hex4          (hex4),
		.hex5          (hex5),
		.ledr          (ledr)
	);

	// 40 ns period
	always #20 CLOCK_50 = ~CLOCK_50;

	// ========================================
	// Reference model and helpers
	// ========================================
	// Expected digits and LEDs for one accepted word
	function automatic logic [OUT_W-1:0] expected_outputs(input logic [WORD_W-1:0] word,
			input logic ready);
		logic [3:0]       cmd;
		logic [7:0]       x_byte;
		logic [7:0]       y_byte;
		logic [LED_W-1:0] leds;
		// Command in [3:0], x from bit 4, y from bit 18
		cmd    = word[3:0];
		x_byte = word[11:4];
		y_byte = word[25:18];
		leds    = '0;
		leds[3:0] = cmd;
		leds[8]   = ready;
		return {SEG_TABLE[y_byte[7:4]], SEG_TABLE[y_byte[3:0]],
			SEG_TABLE[x_byte[7:4]], SEG_TABLE[x_byte[3:0]], SEG_BLANK, SEG_BLANK, leds};
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_display(input logic [WORD_W-1:0] word, input logic ready,
			input string what);
		logic [OUT_W-1:0] got;
		logic [OUT_W-1:0] exp;
		got = {hex5, hex4, hex3, hex2, hex1, hex0, ledr};
		exp = expected_outputs(word, ready);
		assert (got == exp) else
			fail_run($sformatf("[FAIL] %0t: %s, word %h shows %h, expected %h",
				$time, what, word, got, exp));
	endtask

	// Queue push lands 1 ns after the edge, FIFO model updates at 2 ns
	task automatic push_word(input logic [WORD_W-1:0] word);
		@(posedge CLOCK_50);
		#1;
		fifo_q.push_back(word);
		expect_q.push_back(word);
		words_sent++;
	endtask

	task automatic pulse_set_ready();
		@(posedge CLOCK_50);
		#2;
		set_ready = 1'b1;
		@(posedge CLOCK_50);
		#2;
		set_ready = 1'b0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge CLOCK_50);
		#2;
	endtask

	// Block until n words have reached the display
	task automatic wait_shown(input int n);
		while (shown_count < n) @(posedge CLOCK_50);
		#2;
	endtask

	// ========================================
	// FIFO model
	// ========================================
	initial begin : fifo_model
		logic popped;
		fifo_empty    = 1'b1;
		fifo_readdata = '0;
		forever begin
			// Strobe sampled mid-cycle
			@(negedge CLOCK_50);
			popped = (fifo_read === 1'b1);
			if (popped) begin
				read_count++;
			end
			@(posedge CLOCK_50);
			#2;
			if (popped && fifo_q.size() == 0) begin
				fail_run("FIFO read while the FIFO model was empty");
			end else if (popped) begin
				fifo_readdata = fifo_q.pop_front();
			end
			fifo_empty = (fifo_q.size() == 0);
		end
	end

	// ========================================
	// Compare on each accepted word
	// ========================================
	initial begin : compare_display
		logic [WORD_W-1:0] word;
		// Skips the X to 0 step of ledr[8] in reset
		wait (checks_armed);
		forever begin
			@(negedge ledr[8]);
			// Latch and ready clear in the same step, let the decode settle
			#1;
			if (expect_q.size() == 0) begin
				fail_run("Display updated although no word was waiting");
			end else begin
				word = expect_q.pop_front();
				last_word = word;
				shown_count++;
				check_display(word, 1'b0, "accepted word");
			end
		end
	end

	initial begin : watchdog
		repeat (LIMIT_CYCLES) @(posedge CLOCK_50);
		fail_run($sformatf("Run timed out after %0d clock cycles", LIMIT_CYCLES));
	end

	// ========================================
	// Stimulus
	// ========================================
	initial begin : stimulus
		int rd_base;
		int shown_base;
		int i;
		reset     = 1'b1;
		set_ready = 1'b0;
		repeat (3) @(posedge CLOCK_50);
		#2;
		reset        = 1'b0;
		checks_armed = 1'b1;

		// Idle after reset
		wait_cycles(1);
		assert (fifo_read == 1'b0) else
			fail_run($sformatf("[FAIL] %0t: fifo_read high after reset", $time));
		check_display('0, 1'b0, "after reset");

		// Single word, ready already set
		pulse_set_ready();
		push_word($random(seed));
		wait_shown(1);
		wait_cycles(2);
		assert (read_count == 1) else
			fail_run($sformatf("[FAIL] %0t: %0d read pulses for one word", $time, read_count));

		// Back-pressure, two words waiting with ready low
		rd_base    = read_count;
		shown_base = shown_count;
		push_word($random(seed));
		push_word($random(seed));
		wait_cycles(50);
		assert (read_count == rd_base + 1) else
			fail_run($sformatf("[FAIL] %0t: %0d read pulses under back-pressure, expected 1",
				$time, read_count - rd_base));
		assert (shown_count == shown_base) else
			fail_run($sformatf("[FAIL] %0t: display changed with ready low", $time));
		check_display(last_word, 1'b0, "under back-pressure");
		pulse_set_ready();
		wait_shown(shown_base + 1);
		pulse_set_ready();
		wait_shown(shown_base + 2);

		// Random stream, one button press per word
		shown_base = shown_count;
		for (i = 0; i < NUM_RANDOM; i++) begin
			push_word($random(seed));
		end
		for (i = 0; i < NUM_RANDOM; i++) begin
			pulse_set_ready();
			wait_shown(shown_base + i + 1);
		end

		// Button held down, uneven arrival gaps
		shown_base = shown_count;
		@(posedge CLOCK_50);
		#2;
		set_ready = 1'b1;
		for (i = 0; i < NUM_HELD; i++) begin
			push_word($random(seed));
			wait_cycles(i % 3);
		end
		wait_shown(shown_base + NUM_HELD);
		@(posedge CLOCK_50);
		#2;
		set_ready = 1'b0;
		wait_cycles(20);
		assert (read_count == words_sent) else
			fail_run($sformatf("[FAIL] %0t: %0d read pulses for %0d words",
				$time, read_count, words_sent));

		if (expect_q.size() == 0 && shown_count == TOTAL_WORDS) begin
			$display("All tests passed");
			$finish;
		end else begin
			fail_run("Run ended with words sent but never displayed");
		end
	end

endmodule

`default_nettype wire

// File: hps_cmd_bridge.f
hw/bridge_pkg.sv
hw/display_pkg.sv
hw/cmd_fifo_reader.sv
hw/cmd_controller.sv
hw/seg_display.sv
hw/hps_cmd_bridge_top.sv
dv/hps_cmd_bridge_sva.sv
dv/hps_cmd_bridge_tb.sv

// File: hw/bridge_pkg.sv
`default_nettype none

// Command word layout and reader states shared across the bridge
package bridge_pkg;

	// ========================================
	// FIFO word and field widths
	// ========================================
	localparam int WORD_W  = 32;
	// Command number, low bits of the word
	localparam int CMD_W   = 4;
	// Width of x and of y
	localparam int COORD_W = 14;

	// Field positions inside one FIFO word
	// cmd in [3:0], x in [17:4], y in [31:18]
	localparam int CMD_LSB = 0;
	localparam int X_LSB   = 4;
	localparam int Y_LSB   = 18;

	// ========================================
	// Reader FSM states
	// ========================================
	typedef enum logic [1:0] {
		AWAIT_DATA,
		DELAY_READ_DATA,
		READ_DATA,
		DELAY_AWAIT_DATA
	} reader_state_e;

endpackage

`default_nettype wire

// File: hw/cmd_controller.sv
`timescale 1ns/100ps
`default_nettype none

// Paces the bridge with a ready flag and keeps the last accepted command
module cmd_controller
	import bridge_pkg::*;
(
	input  logic               CLOCK_50,
	input  logic               reset,
	// Push button, already inverted
	input  logic               set_ready,
	// From the reader
	input  logic               cmd_valid,
	input  logic [CMD_W-1:0]   cmd_num,
	input  logic [COORD_W-1:0] x_value,
	input  logic [COORD_W-1:0] y_value,
	// Ready level back to the reader, also shown on an LED
	output logic               in_ready,
	// Latched command for the display
	output logic [CMD_W-1:0]   cur_cmd,
	output logic [COORD_W-1:0] cur_x,
	output logic [COORD_W-1:0] cur_y
);

	// ========================================
	// Ready flag
	// ========================================
	// Acceptance beats the button if both land together
	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			in_ready <= 1'b0;
		end else if (cmd_valid) begin
			in_ready <= 1'b0;
		end else if (set_ready) begin
			in_ready <= 1'b1;
		end
	end

	// ========================================
	// Command latch
	// ========================================
	// Reader only pulses cmd_valid while ready is high,
	// so no second check of ready here
	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			// Display shows zeros out of reset
			cur_cmd <= '0;
			cur_x   <= '0;
			cur_y   <= '0;
		end else if (cmd_valid) begin
			cur_cmd <= cmd_num;
			cur_x   <= x_value;
			cur_y   <= y_value;
		end
	end

endmodule

`default_nettype wire

// File: hw/cmd_fifo_reader.sv
`timescale 1ns/100ps
`default_nettype none

// Polls the processor-to-FPGA FIFO and unpacks one command word per read
module cmd_fifo_reader
	import bridge_pkg::*;
(
	input  logic               CLOCK_50,
	input  logic               reset,
	// FIFO side
	input  logic               fifo_empty,
	input  logic [WORD_W-1:0]  fifo_readdata,
	output logic               fifo_read,
	// Controller side
	input  logic               in_ready,
	output logic               cmd_valid,
	output logic [CMD_W-1:0]   cmd_num,
	output logic [COORD_W-1:0] x_value,
	output logic [COORD_W-1:0] y_value
);

	// ========================================
	// FSM state
	// ========================================
	reader_state_e state;

	// Word is consumed only when the controller can take it
	logic capture;

	assign capture = (state == READ_DATA) && in_ready;

	// ========================================
	// State and strobes
	// ========================================
	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			state     <= AWAIT_DATA;
			fifo_read <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			// Strobes are single-cycle unless set below
			fifo_read <= 1'b0;
			cmd_valid <= 1'b0;
			case (state)
				AWAIT_DATA: begin
					// Something queued, request one word
					if (!fifo_empty) begin
						fifo_read <= 1'b1;
						state     <= DELAY_READ_DATA;
					end
				end
				DELAY_READ_DATA: begin
					// Read strobe drops here, data shows up next cycle
					state <= READ_DATA;
				end
				READ_DATA: begin
					// Hold here under back-pressure, FIFO output stays put
					if (in_ready) begin
						cmd_valid <= 1'b1;
						state     <= DELAY_AWAIT_DATA;
					end
				end
				DELAY_AWAIT_DATA: begin
					// One idle cycle while the controller drops ready
					state <= AWAIT_DATA;
				end
				default: begin
					state <= AWAIT_DATA;
				end
			endcase
		end
	end

	// ========================================
	// Field capture
	// ========================================
	// Unpack the word at the package field positions
	always_ff @(posedge CLOCK_50) begin
		if (capture) begin
			cmd_num <= fifo_readdata[CMD_LSB +: CMD_W];
			x_value <= fifo_readdata[X_LSB +: COORD_W];
			y_value <= fifo_readdata[Y_LSB +: COORD_W];
		end
	end

endmodule

`default_nettype wire

// File: hw/display_pkg.sv
`default_nettype none

// Board display constants for the seven-segment digits and LEDs
package display_pkg;

	// Six digits, hex0 to hex5
	localparam int NUM_DIGITS = 6;
	// Segments a to g, bit 0 is segment a, active low
	localparam int SEG_W = 7;
	// Red LED bank
	localparam int LED_W = 10;

	// All segments dark
	localparam logic [SEG_W-1:0] SEG_BLANK = 7'h7f;

	// Hex glyphs 0 to F, active low, index is the nibble value
	localparam logic [SEG_W-1:0] SEG_TABLE [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30,
		7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03,
		7'h46, 7'h21, 7'h06, 7'h0e
	};

endpackage

`default_nettype wire

// File: hw/hps_cmd_bridge_top.sv
`timescale 1ns/100ps
`default_nettype none

// Command bridge from the processor FIFO to the board display
module hps_cmd_bridge_top
	import bridge_pkg::*;
	import display_pkg::*;
(
	input  logic              CLOCK_50,
	input  logic              reset,
	// Processor-to-FPGA FIFO
	input  logic              fifo_empty,
	input  logic [WORD_W-1:0] fifo_readdata,
	output logic              fifo_read,
	// Inverted push button
	input  logic              set_ready,
	// Board display
	output logic [SEG_W-1:0]  hex0,
	output logic [SEG_W-1:0]  hex1,
	output logic [SEG_W-1:0]  hex2,
	output logic [SEG_W-1:0]  hex3,
	output logic [SEG_W-1:0]  hex4,
	output logic [SEG_W-1:0]  hex5,
	output logic [LED_W-1:0]  ledr
);

	// ========================================
	// Reader to controller
	// ========================================
	logic               cmd_valid;
	logic [CMD_W-1:0]   cmd_num;
	logic [COORD_W-1:0] x_value;
	logic [COORD_W-1:0] y_value;
	// Ready level, paces the reader and lights an LED
	logic               in_ready;

	// Controller to display
	logic [CMD_W-1:0]   cur_cmd;
	logic [COORD_W-1:0] cur_x;
	logic [COORD_W-1:0] cur_y;

	// FIFO polling and word unpack
	cmd_fifo_reader cmd_fifo_reader_i (
		.CLOCK_50      (CLOCK_50),
		.reset         (reset),
		.fifo_empty    (fifo_empty),
		.fifo_readdata (fifo_readdata),
		.fifo_read     (fifo_read),
		.in_ready      (in_ready),
		.cmd_valid     (cmd_valid),
		.cmd_num       (cmd_num),
		.x_value       (x_value),
		.y_value       (y_value)
	);

	// Ready flag and command latch
	cmd_controller cmd_controller_i (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.set_ready (set_ready),
		.cmd_valid (cmd_valid),
		.cmd_num   (cmd_num),
		.x_value   (x_value),
		.y_value   (y_value),
		.in_ready  (in_ready),
		.cur_cmd   (cur_cmd),
		.cur_x     (cur_x),
		.cur_y     (cur_y)
	);

	// Combinational view of the latched command
	seg_display seg_display_i (
		.cur_cmd    (cur_cmd),
		.cur_x      (cur_x),
		.cur_y      (cur_y),
		.ctrl_ready (in_ready),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex2       (hex2),
		.hex3       (hex3),
		.hex4       (hex4),
		.hex5       (hex5),
		.ledr       (ledr)
	);

endmodule

`default_nettype wire

// File: hw/seg_display.sv
`timescale 1ns/100ps
`default_nettype none

// Seven-segment and LED view of the latched command
module seg_display
	import bridge_pkg::*;
	import display_pkg::*;
(
	input  logic [CMD_W-1:0]   cur_cmd,
	input  logic [COORD_W-1:0] cur_x,
	input  logic [COORD_W-1:0] cur_y,
	input  logic               ctrl_ready,
	output logic [SEG_W-1:0]   hex0,
	output logic [SEG_W-1:0]   hex1,
	output logic [SEG_W-1:0]   hex2,
	output logic [SEG_W-1:0]   hex3,
	output logic [SEG_W-1:0]   hex4,
	output logic [SEG_W-1:0]   hex5,
	output logic [LED_W-1:0]   ledr
);

	// ========================================
	// Nibble decode
	// ========================================
	// Hex glyph lookup, active low
	function automatic logic [SEG_W-1:0] hex_to_seg(input logic [3:0] nibble);
		return SEG_TABLE[nibble];
	endfunction

	// One pattern per digit, index 0 is hex0
	logic [SEG_W-1:0] digits [NUM_DIGITS];

	always_comb begin
		// Two right-hand digits unused
		digits[0] = SEG_BLANK;
		digits[1] = SEG_BLANK;
		// Low byte of x
		digits[2] = hex_to_seg(cur_x[3:0]);
		digits[3] = hex_to_seg(cur_x[7:4]);
		// Low byte of y
		digits[4] = hex_to_seg(cur_y[3:0]);
		digits[5] = hex_to_seg(cur_y[7:4]);
	end

	assign hex0 = digits[0];
	assign hex1 = digits[1];
	assign hex2 = digits[2];
	assign hex3 = digits[3];
	assign hex4 = digits[4];
	assign hex5 = digits[5];

	// ========================================
	// LEDs
	// ========================================
	always_comb begin
		ledr = '0;
		// Command number on the low four LEDs
		ledr[CMD_W-1:0] = cur_cmd;
		// Ready flag, falls on each accepted word
		ledr[8] = ctrl_ready;
	end

endmodule

`default_nettype wire
